/* tb/emult_stimulus.txt */
// columns: test number, operand a, operand b, expected c.
// each vector is 4 groups of two 18-bit lanes, lanes 7,6 leftmost.
0 01003fc00_00007ffff_7fffc8000_ff803fa00 030000a00_008000200_7fffc1400_fe0000600 03003f600_000040000_ffc028000_01003f700
1 01803ffff_ffffc0000_ff0000400_20001ffff 000040601_00c000000_028000c00_05001ffff 0000bfffe_ffffc0000_fd8000c00_a0003ff00
2 ff803fa00_7fffc8000_00007ffff_01003fc00 fe0000600_7fffc1400_008000200_030000a00 01003f700_ffc028000_000040000_03003f600
3 20001ffff_ff0000400_ffffc0000_01803ffff 05001ffff_028000c00_00c000000_000040601 a0003ff00_fd8000c00_ffffc0000_0000bfffe
4 00007ffff_ff803fa00_ffffc0000_20001ffff 008000200_fe0000600_00c000000_05001ffff 000040000_01003f700_ffffc0000_a0003ff00
5 01003fc00_7fffc8000_01803ffff_ff0000400 030000a00_7fffc1400_000040601_028000c00 03003f600_ffc028000_0000bfffe_fd8000c00
6 000000000_000000000_000000000_00007ffff 000000000_000000000_000000000_008000200 000000000_000000000_000000000_000040000
7 7fffc8000_7fffc8000_20001ffff_20001ffff 7fffc1400_7fffc1400_05001ffff_05001ffff ffc028000_ffc028000_a0003ff00_a0003ff00
8 ffffc0000_01803ffff_ff803fa00_7fffc8000 00c000000_000040601_fe0000600_7fffc1400 ffffc0000_0000bfffe_01003f700_ffc028000
9 ff0000400_01003fc00_000000000_ff803fa00 028000c00_030000a00_000000000_fe0000600 fd8000c00_03003f600_000000000_01003f700
10 00007ffff_00007ffff_01803ffff_01803ffff 008000200_008000200_000040601_000040601 000040000_000040000_0000bfffe_0000bfffe
11 20001ffff_01003fc00_ff803fa00_ffffc0000 05001ffff_030000a00_fe0000600_00c000000 a0003ff00_03003f600_01003f700_ffffc0000

/* filelist.f */
src/emult_pkg.sv
src/operand_capture.sv
src/dsp_mult_pair.sv
src/result_round.sv
src/elementwise_mult_top.sv
tb/tb_elementwise_mult.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_elementwise_mult
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides the result, the binary status alone is not enough.
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All tests passed!" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_elementwise_mult.sv */
module tb_elementwise_mult;
	timeunit 1ns;
	timeprecision 1ps;

	import emult_pkg::*;

	localparam int MAX_VEC = 64;
	localparam int CLK_HALF = 10;

	logic clk;
	logic reset;
	logic i_valid;
	logic i_ready;
	data_vec_t i_a;
	data_vec_t i_b;
	data_vec_t o_c;
	logic o_valid;
	logic o_ready;

	// number, a, b and expected c per vector.
	logic [LANES*DATA_W-1:0] stim_mem [0:4*MAX_VEC-1];
	int num_vec = 0;

	data_vec_t drive_exp;  // expected result of the vector on the inputs.
	data_vec_t exp_q[$];
	int acc_cycle_q[$];
	data_vec_t exp_head;
	int acc_head;
	int cycle = 0;
	int accepted = 0;
	int delivered = 0;
	bit check_latency = 0;
	string cur_test = "reset";
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic [31:0] rng_state = 32'h2479751a;

	elementwise_mult_top u_elementwise_mult_top (
		.clk     (clk),
		.reset   (reset),
		.i_valid (i_valid),
		.i_ready (i_ready),
		.i_a     (i_a),
		.i_b     (i_b),
		.o_c     (o_c),
		.o_valid (o_valid),
		.o_ready (o_ready)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// lcg step giving a percentage roll.
	function automatic int roll_percent();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return int'(rng_state[31:16]) % 100;
	endfunction

	// preset of a word the file leaves empty, never a test number.
	function automatic logic [LANES*DATA_W-1:0] empty_word(input int addr);
		return ~(LANES*DATA_W)'(addr);
	endfunction

	task automatic check_vec(input string what, input data_vec_t exp, input data_vec_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s %s expected %b actual %b", cur_test, what, exp, act);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output monitor sampling the values before each edge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin
		cycle++;
		if (!reset) begin
			check_bit("o_ready", i_ready, o_ready);
			if (!i_ready)
				check_bit("o_valid during stall", 1'b0, o_valid);
			if (o_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("%s: a result came out with no input pending", cur_test);
				end else begin
					exp_head = exp_q.pop_front();
					acc_head = acc_cycle_q.pop_front();
					check_vec("o_c", exp_head, o_c);
					if (check_latency && (cycle - acc_head != PIPE_DEPTH)) begin
						errors++;
						$display("mismatch %s latency expected %0d actual %0d",
							cur_test, PIPE_DEPTH, cycle - acc_head);
					end
					delivered++;
				end
			end
			if (i_ready && i_valid) begin  // accepted on this edge.
				exp_q.push_back(drive_exp);
				acc_cycle_q.push_back(cycle);
				accepted++;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_test(input string name, input int first, input int count,
			input int stall_pct, input int bubble_pct);
		int idx;
		int err_before;
		logic rdy;
		logic vld;
		idx = first;
		err_before = errors;
		cur_test = name;
		check_latency = (stall_pct == 0);
		accepted = 0;
		delivered = 0;
		while (idx < first + count) begin
			@(posedge clk);
			rdy = (roll_percent() >= stall_pct);
			vld = (roll_percent() >= bubble_pct);
			i_ready <= rdy;
			i_valid <= vld;
			i_a <= stim_mem[4*idx+1];
			i_b <= stim_mem[4*idx+2];
			drive_exp <= stim_mem[4*idx+3];
			if (rdy && vld)
				idx++;
		end
		@(posedge clk);
		i_valid <= 1'b0;
		i_ready <= 1'b1;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (PIPE_DEPTH + 2) @(posedge clk);  // room for a stray result.
		if (delivered != accepted) begin
			errors++;
			$display("%s: %0d inputs accepted but %0d results delivered",
				name, accepted, delivered);
		end
		tests_run++;
		if (errors != err_before)
			tests_failed++;
		$display("test %s: %s (%0d errors)", name,
			(errors == err_before) ? "ok" : "FAILED", errors - err_before);
	endtask

	initial begin
		int i;
		i_valid = 1'b0;
		i_ready = 1'b1;
		i_a = '0;
		i_b = '0;
		drive_exp = '0;
		reset = 1'b1;
		for (i = 0; i < 4*MAX_VEC; i++)
			stim_mem[i] = empty_word(i);
		$readmemh("tb/emult_stimulus.txt", stim_mem);
		i = 0;
		while (i < MAX_VEC && stim_mem[4*i] != empty_word(4*i))
			i++;
		num_vec = i;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk);
		check_bit("o_valid", 1'b0, o_valid);
		check_vec("o_c", '0, o_c);
		check_bit("o_ready", 1'b1, o_ready);
		tests_run++;
		if (errors != 0)
			tests_failed++;
		$display("test reset: %s (%0d errors)", (errors == 0) ? "ok" : "FAILED", errors);

		run_test("single", 0, 1, 0, 0);
		run_test("back_to_back", 0, num_vec, 0, 0);
		run_test("ready_stalls", 0, num_vec, 30, 0);
		run_test("valid_bubbles", 0, num_vec, 0, 30);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && num_vec != 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// watchdog.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		wait (num_vec != 0);
		repeat ((1 + 3*num_vec) * 8 + 100) @(posedge clk);
		$display("timeout in %s: results never arrived, %0d still pending",
			cur_test, exp_q.size());
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed + 1, checks, errors + 1);
		$display("Test failures found");
		$finish;
	end

endmodule

/* src/elementwise_mult_top.sv */
module elementwise_mult_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_valid,
	input  logic                 i_ready,
	input  emult_pkg::data_vec_t i_a,
	input  emult_pkg::data_vec_t i_b,
	output emult_pkg::data_vec_t o_c,
	output logic                 o_valid,
	output logic                 o_ready
);
	import emult_pkg::*;

	operands_t operands;  // capture stage out.
	logic capture_valid;
	prod_vec_t products;  // full-width products, all lanes.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// input capture, 1 cycle.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// i_ready is the global enable of every stage.
	operand_capture u_operand_capture (
		.clk        (clk),
		.reset      (reset),
		.i_enable   (i_ready),
		.i_valid    (i_valid),
		.i_a        (i_a),
		.i_b        (i_b),
		.o_operands (operands),
		.o_valid    (capture_valid)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// multiplier pairs, 2 cycles.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	generate
		for (genvar p = 0; p < PAIRS; p++) begin : g_pair
			dsp_mult_pair u_dsp_mult_pair (
				.clk      (clk),
				.reset    (reset),
				.i_enable (i_ready),
				.i_ax     (operands.a[2*p]),
				.i_ay     (operands.b[2*p]),
				.i_bx     (operands.a[2*p+1]),
				.i_by     (operands.b[2*p+1]),
				.o_res_a  (products[2*p]),
				.o_res_b  (products[2*p+1])
			);
		end
	endgenerate

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// rounding and output handshake, 2 cycles.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	result_round u_result_round (
		.clk      (clk),
		.reset    (reset),
		.i_enable (i_ready),
		.i_valid  (capture_valid),
		.i_prod   (products),
		.o_c      (o_c),
		.o_valid  (o_valid)
	);

	assign o_ready = i_ready;  // no buffering, the source sees the sink directly.

endmodule

/* src/result_round.sv */
module result_round (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_enable,
	input  logic                 i_valid,
	input  emult_pkg::prod_vec_t i_prod,
	output emult_pkg::data_vec_t o_c,
	output logic                 o_valid
);
	import emult_pkg::*;

	// the products arrive MULT_STAGES edges after i_valid.
	localparam int VALID_LEN = MULT_STAGES + ROUND_STAGES;

	prod_vec_t floor_q;
	prod_vec_t ceil_q;
	logic [LANES-1:0] is_ceil_q;
	data_vec_t c_q;
	logic [VALID_LEN-1:0] valid_sr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1, floor and ceiling candidates.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// round half up: the ceiling wins when the first dropped
	// fraction bit is set, whatever the sign.
	always_ff @(posedge clk) begin
		if (reset) begin
			floor_q <= '0;
			ceil_q <= '0;
			is_ceil_q <= '0;
		end else if (i_enable) begin
			for (int k = 0; k < LANES; k++) begin
				floor_q[k] <= i_prod[k] >>> FRAC_W;      // arithmetic, keeps the sign.
				ceil_q[k] <= (i_prod[k] >>> FRAC_W) + 1;
				is_ceil_q[k] <= i_prod[k][FRAC_W-1];
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 2, select and truncate.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// only the low DATA_W bits are kept, large products wrap.
	always_ff @(posedge clk) begin
		if (reset) begin
			c_q <= '0;
		end else if (i_enable) begin
			for (int k = 0; k < LANES; k++) begin
				if (is_ceil_q[k]) begin
					c_q[k] <= ceil_q[k][DATA_W-1:0];
				end else begin
					c_q[k] <= floor_q[k][DATA_W-1:0];
				end
			end
		end
	end

	assign o_c = c_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// valid delay line.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one chain for all lanes, it moves with the same enable as the data.
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_sr <= '0;
		end else if (i_enable) begin
			valid_sr <= {valid_sr[VALID_LEN-2:0], i_valid};
		end
	end

	// a result only leaves on an edge the sink accepts.
	assign o_valid = valid_sr[VALID_LEN-1] & i_enable;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// no result is offered while the sink stalls the pipe.
	a_no_valid_in_stall: assert property (
		@(posedge clk) disable iff (reset)
		!i_enable |-> !o_valid
	) else $error("result_round o_valid high while stalled");

	// the pending result is still there after the stall.
	a_result_held: assert property (
		@(posedge clk) disable iff (reset)
		!i_enable |=> $stable(o_c) && $stable(valid_sr)
	) else $error("result_round output changed during a stall");

endmodule

/* src/dsp_mult_pair.sv */
module dsp_mult_pair (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_enable,
	input  emult_pkg::data_t i_ax,
	input  emult_pkg::data_t i_ay,
	input  emult_pkg::data_t i_bx,
	input  emult_pkg::data_t i_by,
	output emult_pkg::prod_t o_res_a,
	output emult_pkg::prod_t o_res_b
);
	import emult_pkg::*;

	// stage 1 operand registers.
	data_t ax_q;
	data_t ay_q;
	data_t bx_q;
	data_t by_q;

	// stage 2 product registers.
	prod_t res_a_q;
	prod_t res_b_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// dual 18x18 signed multiplier with two register stages.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// input side of the dsp block.
	always_ff @(posedge clk) begin
		if (reset) begin
			ax_q <= '0;
			ay_q <= '0;
			bx_q <= '0;
			by_q <= '0;
		end else if (i_enable) begin
			ax_q <= i_ax;
			ay_q <= i_ay;
			bx_q <= i_bx;
			by_q <= i_by;
		end
	end

	// both factors are sign extended to the full 36-bit width,
	// so the product is exact.
	always_ff @(posedge clk) begin
		if (reset) begin
			res_a_q <= '0;
			res_b_q <= '0;
		end else if (i_enable) begin
			res_a_q <= prod_t'(ax_q) * prod_t'(ay_q);  // lane 2p.
			res_b_q <= prod_t'(bx_q) * prod_t'(by_q);  // lane 2p+1.
		end
	end

	assign o_res_a = res_a_q;
	assign o_res_b = res_b_q;

endmodule

/* src/operand_capture.sv */
module operand_capture (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_enable,
	input  logic                 i_valid,
	input  emult_pkg::data_vec_t i_a,
	input  emult_pkg::data_vec_t i_b,
	output emult_pkg::operands_t o_operands,
	output logic                 o_valid
);
	import emult_pkg::*;

	operands_t operands_q;
	logic valid_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// input register.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a vector is taken on every enabled edge and a low i_valid
	// lets a bubble into the pipe.
	always_ff @(posedge clk) begin
		if (reset) begin
			operands_q <= '0;
			valid_q <= 1'b0;
		end else if (i_enable) begin
			operands_q.a <= i_a;
			operands_q.b <= i_b;
			valid_q <= i_valid;
		end
	end

	assign o_operands = operands_q;
	assign o_valid = valid_q;  // feeds the single valid chain in result_round.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a stalled edge must not drop or invent an input.
	a_valid_held: assert property (
		@(posedge clk) disable iff (reset)
		!i_enable |=> $stable(o_valid)
	) else $error("operand_capture valid changed during a stall");

endmodule

/* src/emult_pkg.sv */
package emult_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// lane geometry.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int LANES = 8;          // must be even, 48 also builds.
	localparam int PAIRS = LANES / 2;  // one dual-multiplier dsp block per two lanes.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fixed-point format.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// sign bit, 7 integer bits and 10 fraction bits.
	localparam int DATA_W = 18;
	localparam int FRAC_W = 10;

	// full signed product, 20 fraction bits before rounding.
	localparam int PROD_W = 2 * DATA_W;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pipeline depths, counted in enabled clock edges.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int MULT_STAGES = 2;   // operand register, product register.
	localparam int ROUND_STAGES = 2;  // floor/ceil register, result register.

	// the extra stage is the input capture register.
	localparam int PIPE_DEPTH = 1 + MULT_STAGES + ROUND_STAGES;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic signed [DATA_W-1:0] data_t;  // one lane value.
	typedef logic signed [PROD_W-1:0] prod_t;  // one unrounded product.

	// lane k sits at bits [k*DATA_W +: DATA_W].
	typedef data_t [LANES-1:0] data_vec_t;
	typedef prod_t [LANES-1:0] prod_vec_t;

	// captured operand bundle, a in the upper half.
	typedef struct packed {
		data_vec_t a;
		data_vec_t b;
	} operands_t;

endpackage
